// ==== include/uop_defines.svh ====
`ifndef UOP_DEFINES_SVH
`define UOP_DEFINES_SVH

// Word and list sizes
`define UOP_WORD_W 32
`define UOP_REG_CNT 16
`define UOP_REG_IDX_W 4 // Register number width
`define UOP_CNT_W 5 // Holds 0..16 registers

// Scratch register number in a micro-op register field
`define UOP_RZ_IDX 15

// Common ARM field positions
`define UOP_COND_HI 31
`define UOP_COND_LO 28
`define UOP_RN_HI 19
`define UOP_RN_LO 16
`define UOP_RD_HI 15
`define UOP_RD_LO 12

// LDM/STM control bits
`define UOP_P_BIT 24 // Pre index
`define UOP_U_BIT 23 // Up (add)
`define UOP_W_BIT 21 // Base writeback
`define UOP_L_BIT 20 // Load

`endif

// ==== design/uopPkg.sv ====
`include "uop_defines.svh"

package uopPkg;

	// Macro-op class found by the receiver
	typedef enum logic [1:0] {
		classPass,
		classRsr,
		classLdm,
		classStm
	} macroClassT;

	typedef enum logic [1:0] {
		seqIdle, // First micro-op of a new macro-op
		seqRsrOp, // RSR second half
		seqXfer, // Later LDM/STM transfers
		seqWriteback // Base update after the list
	} seqStateT;

	// Data-processing opcodes the expander emits
	typedef enum logic [3:0] {
		opSub = 4'b0010,
		opAdd = 4'b0100,
		opMov = 4'b1101
	} dpOpT;

	typedef struct packed {
		logic [`UOP_WORD_W-1:0] instr;
		macroClassT opClass;
	} macroOpT;

	typedef struct packed {
		logic [`UOP_WORD_W-1:0] instr;
		logic useRz; // Rz-marked field selects scratch register
		logic holdFlags; // Do not update flags
		logic forwardRz; // Base comes from forwarded Rz
		logic last; // Final micro-op of the instruction
		logic uopValid;
	} uopT;

	typedef struct packed {
		logic [`UOP_REG_IDX_W-1:0] nextReg; // Lowest listed register
		logic [`UOP_CNT_W-1:0] remaining; // Registers still listed
	} scanT;

endpackage

// ==== design/instrReceiver.sv ====
`timescale 1ns/1ps
`include "uop_defines.svh"

module instrReceiver (
	input  logic clk,
	input  logic reset,
	input  logic [`UOP_WORD_W-1:0] instrIn,
	input  logic instrReq,
	output logic instrAck,
	output uopPkg::macroOpT macroOp,
	output logic macroValid,
	input  logic macroDone
);
	import uopPkg::*;

	typedef enum logic [1:0] {
		rxWait, // Idle, ack low
		rxBusy, // Expansion in progress
		rxAcking // Ack high until req drops
	} rxStateT;

	rxStateT rxState;
	macroClassT inClass;
	logic bxPattern;

	// BX/BLX register form looks like RSR but must pass through
	assign bxPattern = (instrIn[27:6] == {8'b0001_0010, 12'hFFF, 2'b00});

	always_comb begin
		if (instrIn[27:25] == 3'b100) begin // Block transfer
			inClass = instrIn[`UOP_L_BIT] ? classLdm : classStm;
		end else if (instrIn[27:25] == 3'b000 && !instrIn[7] && instrIn[4] && !bxPattern) begin
			inClass = classRsr; // Shift amount from a register
		end else begin
			inClass = classPass;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rxState <= rxWait;
		end else begin
			case (rxState)
				rxWait: if (instrReq) rxState <= rxBusy;
				rxBusy: if (macroDone) rxState <= rxAcking; // Last micro-op accepted
				rxAcking: if (!instrReq) rxState <= rxWait;
				default: rxState <= rxWait;
			endcase
		end
	end

	// Latch word and class on the accepting edge
	always_ff @(posedge clk) begin
		if (rxState == rxWait && instrReq) begin
			macroOp.instr <= instrIn;
			macroOp.opClass <= inClass;
		end
	end

	assign macroValid = (rxState == rxBusy);
	assign instrAck = (rxState == rxAcking);

	// Four-phase rule, ack only answers a held request
	assert property (@(posedge clk) disable iff (reset)
		$rose(instrAck) |-> $past(instrReq));

endmodule

// ==== design/regListScanner.sv ====
`timescale 1ns/1ps
`include "uop_defines.svh"

module regListScanner (
	input  logic clk,
	input  logic reset,
	input  logic [`UOP_REG_CNT-1:0] listIn,
	input  logic scanLoad,
	input  logic scanStep,
	output uopPkg::scanT scan
);
	import uopPkg::*;

	logic [`UOP_REG_CNT-1:0] listQ; // Registers not yet transferred
	logic [`UOP_REG_CNT-1:0] work;
	logic [`UOP_REG_CNT-1:0] workNext;

	// A load shows the new list at once so the first transfer needs no extra cycle
	assign work = scanLoad ? listIn : listQ;
	assign workNext = scanStep ? (work & (work - 1'b1)) : work; // Drop lowest set bit

	always_comb begin
		scan.nextReg = '0;
		for (int i = `UOP_REG_CNT - 1; i >= 0; i--) begin
			if (work[i]) begin
				scan.nextReg = i[`UOP_REG_IDX_W-1:0]; // Lowest wins, scanned last
			end
		end
		scan.remaining = `UOP_CNT_W'($countones(work));
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			listQ <= '0;
		end else if (scanLoad || scanStep) begin
			listQ <= workNext;
		end
	end

	// Stepping only ever removes registers
	assert property (@(posedge clk) disable iff (reset)
		!scanLoad |=> ((listQ & ~$past(listQ)) == '0));

endmodule

// ==== design/uopSequencer.sv ====
`timescale 1ns/1ps
`include "uop_defines.svh"

module uopSequencer (
	input  logic clk,
	input  logic reset,
	input  uopPkg::macroOpT macroOp,
	input  logic macroValid,
	output logic macroDone,
	input  uopPkg::scanT scan,
	output logic [`UOP_REG_CNT-1:0] listIn,
	output logic scanLoad,
	output logic scanStep,
	output uopPkg::uopT uopNext,
	input  logic advance
);
	import uopPkg::*;

	seqStateT state, nextState;
	logic [`UOP_CNT_W-1:0] xferCnt; // List size kept for the writeback
	logic [11:0] startOffset;
	logic upBit;
	logic writeBack;
	logic [`UOP_WORD_W-1:0] xferWord;
	logic [`UOP_WORD_W-1:0] word;

	assign listIn = macroOp.instr[`UOP_REG_CNT-1:0];
	assign writeBack = macroOp.instr[`UOP_W_BIT];

	// First address relative to Rn, by P/U
	always_comb begin
		case ({macroOp.instr[`UOP_P_BIT], macroOp.instr[`UOP_U_BIT]})
			2'b00: startOffset = 12'({scan.remaining - 5'd1, 2'b00}); // Decrement after
			2'b01: startOffset = 12'd0; // Increment after
			2'b10: startOffset = 12'({scan.remaining, 2'b00}); // Decrement before
			default: startOffset = 12'd4; // Increment before
		endcase
		upBit = macroOp.instr[`UOP_U_BIT]; // First transfer follows the list direction
	end

	// Pre-indexed immediate word LDR/STR keeping cond and L
	always_comb begin
		xferWord = macroOp.instr;
		xferWord[27:25] = 3'b010;
		xferWord[`UOP_P_BIT] = 1'b1;
		xferWord[`UOP_U_BIT] = 1'b1; // Later transfers walk upward
		xferWord[22] = 1'b0; // Word, not byte
		xferWord[`UOP_W_BIT] = 1'b0;
		xferWord[`UOP_RN_HI:`UOP_RN_LO] = `UOP_REG_IDX_W'(`UOP_RZ_IDX);
		xferWord[`UOP_RD_HI:`UOP_RD_LO] = scan.nextReg;
		xferWord[11:0] = 12'd4;
	end

	always_comb begin
		nextState = state;
		word = macroOp.instr;
		uopNext = '0;
		scanLoad = 1'b0;
		scanStep = 1'b0;
		case (state)
			seqIdle: begin
				uopNext.uopValid = macroValid;
				case (macroOp.opClass)
					classRsr: begin // MOV Rz, Rm <shift> Rs
						word[24:21] = opMov;
						word[20] = 1'b0;
						word[`UOP_RN_HI:`UOP_RN_LO] = '0;
						word[`UOP_RD_HI:`UOP_RD_LO] = `UOP_REG_IDX_W'(`UOP_RZ_IDX);
						uopNext.useRz = 1'b1;
						uopNext.holdFlags = 1'b1;
						nextState = seqRsrOp;
					end
					classLdm, classStm: begin
						scanLoad = macroValid;
						if (scan.remaining == '0) begin // Empty list gives a never-execute no-op
							word = '0;
							word[`UOP_COND_HI:`UOP_COND_LO] = 4'b1111;
							uopNext.last = 1'b1;
						end else begin
							word = xferWord;
							word[`UOP_U_BIT] = upBit;
							word[`UOP_RN_HI:`UOP_RN_LO] = macroOp.instr[`UOP_RN_HI:`UOP_RN_LO];
							word[11:0] = startOffset;
							uopNext.holdFlags = 1'b1;
							uopNext.last = (scan.remaining == 5'd1) && !writeBack;
							scanStep = advance && macroValid;
							if (scan.remaining != 5'd1) begin
								nextState = seqXfer;
							end else if (writeBack) begin
								nextState = seqWriteback;
							end
						end
					end
					default: uopNext.last = 1'b1; // Pass-through as one micro-op
				endcase
				if (!macroValid) begin
					nextState = seqIdle;
				end
			end
			seqRsrOp: begin // Original op with unshifted Rz operand
				word[11:4] = '0;
				word[3:0] = `UOP_REG_IDX_W'(`UOP_RZ_IDX);
				uopNext.useRz = 1'b1;
				uopNext.last = 1'b1;
				uopNext.uopValid = 1'b1;
				nextState = seqIdle;
			end
			seqXfer: begin // Rz + 4 from the previous address
				word = xferWord;
				uopNext.holdFlags = 1'b1;
				uopNext.forwardRz = 1'b1;
				uopNext.uopValid = 1'b1;
				scanStep = advance;
				if (scan.remaining <= 5'd1) begin
					uopNext.last = !writeBack;
					nextState = writeBack ? seqWriteback : seqIdle;
				end
			end
			seqWriteback: begin // Rn = Rn +/- 4n
				word[27:25] = 3'b001;
				word[24:21] = macroOp.instr[`UOP_U_BIT] ? opAdd : opSub;
				word[20] = 1'b0;
				word[`UOP_RD_HI:`UOP_RD_LO] = macroOp.instr[`UOP_RN_HI:`UOP_RN_LO];
				word[11:0] = 12'({xferCnt, 2'b00}); // Rotate field stays zero
				uopNext.holdFlags = 1'b1;
				uopNext.last = 1'b1;
				uopNext.uopValid = 1'b1;
				nextState = seqIdle;
			end
			default: nextState = seqIdle;
		endcase
		uopNext.instr = word;
	end

	assign macroDone = uopNext.uopValid && uopNext.last && advance; // Last one accepted

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= seqIdle;
		end else if (advance) begin
			state <= nextState;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && scanLoad) begin
			xferCnt <= scan.remaining;
		end
	end

	// Micro-ops only while the receiver holds a macro-op
	assert property (@(posedge clk) disable iff (reset)
		uopNext.uopValid |-> macroValid);

endmodule

// ==== design/uopOutput.sv ====
`timescale 1ns/1ps

module uopOutput (
	input  logic clk,
	input  logic reset,
	input  uopPkg::uopT uopNext,
	input  logic stall,
	output logic advance,
	output uopPkg::uopT uop
);
	import uopPkg::*;

	logic stallQ;

	always_ff @(posedge clk) begin
		if (reset) begin
			stallQ <= 1'b0;
		end else begin
			stallQ <= stall; // Back-pressure takes effect a cycle later
		end
	end

	assign advance = !stallQ;

	always_ff @(posedge clk) begin
		if (reset) begin
			uop <= '0; // No valid micro-op after reset
		end else if (advance) begin
			uop <= uopNext;
		end
	end

	// Held micro-op must not change under stall
	assert property (@(posedge clk) disable iff (reset)
		!advance |=> $stable(uop));

endmodule

// ==== design/uopExpander.sv ====
`timescale 1ns/1ps
`include "uop_defines.svh"

module uopExpander (
	input  logic clk,
	input  logic reset,
	input  logic [`UOP_WORD_W-1:0] instrIn,
	input  logic instrReq,
	output logic instrAck,
	input  logic stall,
	output uopPkg::uopT uop
);
	import uopPkg::*;

	macroOpT macroOp;
	logic macroValid;
	logic macroDone;
	scanT scan;
	logic [`UOP_REG_CNT-1:0] listIn;
	logic scanLoad;
	logic scanStep;
	uopT uopNext;
	logic advance;

	instrReceiver instrReceiver_inst (
		.clk(clk),
		.reset(reset),
		.instrIn(instrIn),
		.instrReq(instrReq),
		.instrAck(instrAck),
		.macroOp(macroOp),
		.macroValid(macroValid),
		.macroDone(macroDone)
	);

	regListScanner regListScanner_inst (
		.clk(clk),
		.reset(reset),
		.listIn(listIn),
		.scanLoad(scanLoad),
		.scanStep(scanStep),
		.scan(scan)
	);

	uopSequencer uopSequencer_inst (
		.clk(clk),
		.reset(reset),
		.macroOp(macroOp),
		.macroValid(macroValid),
		.macroDone(macroDone),
		.scan(scan),
		.listIn(listIn),
		.scanLoad(scanLoad),
		.scanStep(scanStep),
		.uopNext(uopNext),
		.advance(advance)
	);

	uopOutput uopOutput_inst (
		.clk(clk),
		.reset(reset),
		.uopNext(uopNext),
		.stall(stall),
		.advance(advance),
		.uop(uop)
	);

endmodule

// ==== verification/uopExpanderTb.sv ====
`timescale 1ns/1ps
`include "uop_defines.svh"

module uopExpanderTb;
	import uopPkg::*;

	logic clk;
	logic reset;
	logic [`UOP_WORD_W-1:0] instrIn;
	logic instrReq;
	logic instrAck;
	logic stall;
	uopT uop;

	uopT expQ[$]; // Expected micro-ops, oldest first
	uopT heldUop; // uop at the previous falling edge
	logic stallD1; // stall driven one falling edge ago
	logic stallD2; // stall driven two falling edges ago
	logic lastSeen;
	int stallPct;
	int errorCount;
	int uopCount;

	uopExpander uopExpander_inst (
		.clk(clk),
		.reset(reset),
		.instrIn(instrIn),
		.instrReq(instrReq),
		.instrAck(instrAck),
		.stall(stall),
		.uop(uop)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	task automatic failRun(input string reason);
		errorCount++;
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			failRun($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, actual,
				expected));
		end
	endtask

	// Reference expansion of one instruction into expQ
	task automatic expandModel(input logic [31:0] w);
		uopT u;
		int n;
		int k;
		logic [11:0] offset;
		logic up;
		logic [3:0] base;
		logic bx;
		n = $countones(w[15:0]);
		bx = (w[27:8] == 20'h12FFF) && (w[7:6] == 2'b00); // BX/BLX register form
		u = '0;
		u.uopValid = 1'b1;
		if (w[27:25] == 3'b100 && n == 0) begin
			u.instr = {4'b1111, 28'd0}; // Never-execute no-op
			u.last = 1'b1;
			expQ.push_back(u);
		end else if (w[27:25] == 3'b100) begin
			k = 0;
			u.holdFlags = 1'b1;
			for (int r = 0; r < 16; r++) begin
				if (w[r]) begin
					if (k == 0) begin
						base = w[`UOP_RN_HI:`UOP_RN_LO];
						up = w[`UOP_U_BIT];
						case (w[`UOP_P_BIT:`UOP_U_BIT]) // Start address by P/U
							2'b00: offset = 12'(4 * (n - 1));
							2'b01: offset = 12'd0;
							2'b10: offset = 12'(4 * n);
							default: offset = 12'd4;
						endcase
					end else begin
						base = 4'(`UOP_RZ_IDX); // Walk up from previous address
						up = 1'b1;
						offset = 12'd4;
					end
					u.instr = {w[31:28], 3'b010, 1'b1, up, 2'b00, w[`UOP_L_BIT], base, 4'(r),
						offset};
					u.forwardRz = (k != 0);
					u.last = (k == n - 1) && !w[`UOP_W_BIT];
					expQ.push_back(u);
					k++;
				end
			end
			if (w[`UOP_W_BIT]) begin // ADD/SUB Rn, Rn, #4n
				u.instr = {w[31:28], 3'b001, w[`UOP_U_BIT] ? 4'b0100 : 4'b0010, 1'b0, w[19:16],
					w[19:16], 12'(4 * n)};
				u.forwardRz = 1'b0;
				u.last = 1'b1;
				expQ.push_back(u);
			end
		end else if (w[27:25] == 3'b000 && !w[7] && w[4] && !bx) begin
			u.useRz = 1'b1;
			u.holdFlags = 1'b1;
			u.instr = {w[31:28], 3'b000, 4'b1101, 1'b0, 4'd0, 4'(`UOP_RZ_IDX), w[11:0]}; // MOV Rz
			expQ.push_back(u);
			u.holdFlags = 1'b0;
			u.last = 1'b1;
			u.instr = {w[31:12], 8'd0, 4'(`UOP_RZ_IDX)}; // Original op on Rz
			expQ.push_back(u);
		end else begin
			u.instr = w; // Pass-through
			u.last = 1'b1;
			expQ.push_back(u);
		end
	endtask

	// One cycle, sample at the falling edge then drive stall
	task automatic clockStep();
		uopT expected;
		@(negedge clk);
		if (stallD2) begin // Output register was not loaded
			checkValue(uop, heldUop, "uop held under stall");
		end else if (uop.uopValid) begin
			if (expQ.size() == 0) begin
				failRun($sformatf("Unexpected extra micro-op %h at %0t", uop, $time));
			end else begin
				expected = expQ.pop_front();
				checkValue(uop, expected, "micro-op");
				lastSeen = lastSeen | uop.last;
				uopCount++;
			end
		end
		heldUop = uop;
		stallD2 = stallD1;
		stall = ($urandom_range(99) < stallPct);
		stallD1 = stall;
	endtask

	// Full four-phase handshake for one instruction
	task automatic sendInstr(input logic [31:0] word);
		int cycles;
		expandModel(word);
		lastSeen = 1'b0;
		instrIn = word;
		instrReq = 1'b1;
		cycles = 0;
		do begin
			clockStep();
			cycles++;
			if (cycles > 1000) failRun($sformatf("Timeout waiting for instrAck on %h", word));
		end while (!instrAck);
		checkValue(lastSeen, 1'b1, "last micro-op seen before ack");
		checkValue(expQ.size(), 0, "micro-ops still expected at ack");
		instrReq = 1'b0;
		cycles = 0;
		do begin
			clockStep();
			cycles++;
			if (cycles > 100) failRun("Timeout waiting for instrAck to fall after req dropped");
		end while (instrAck);
	endtask

	function automatic logic [31:0] randomInstr();
		logic [31:0] w;
		w = $urandom();
		case ($urandom_range(3))
			0: ; // Anything, classified by the model
			1: begin // Register-shifted operand
				w[27:25] = 3'b000;
				w[7] = 1'b0;
				w[4] = 1'b1;
			end
			default: begin // Block transfer, sparse or empty list
				w[27:25] = 3'b100;
				if ($urandom_range(1) == 1) w[15:0] = w[15:0] & 16'($urandom());
				if ($urandom_range(7) == 0) w[15:0] = '0;
			end
		endcase
		return w;
	endfunction

	initial begin
		errorCount = 0;
		uopCount = 0;
		reset = 1'b1;
		instrIn = '0;
		instrReq = 1'b0;
		stall = 1'b0;
		stallD1 = 1'b0;
		stallD2 = 1'b0;
		stallPct = 0;
		lastSeen = 1'b0;
		void'($urandom(7));
		repeat (10) @(negedge clk);
		reset = 1'b0;
		heldUop = uop;
		checkValue(instrAck, 1'b0, "instrAck after reset");
		checkValue(uop.uopValid, 1'b0, "uopValid after reset");
		sendInstr(32'hE0812003); // ADD r2, r1, r3
		sendInstr(32'hE12FFF11); // BX r1 stays whole
		sendInstr(32'hE0812314); // ADD r2, r1, r4, LSL r3
		sendInstr(32'hE8900000); // LDMIA r0, {}
		for (int pu = 0; pu < 4; pu++) begin // Each P/U mode, with writeback
			sendInstr({4'hE, 3'b100, 2'(pu), 2'b01, 1'(pu), 4'd3, 16'h8421});
		end
		stallPct = 35;
		for (int i = 0; i < 300; i++) begin
			sendInstr(randomInstr());
		end
		$display("Checked %0d micro-ops", uopCount);
		if (errorCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+include
design/uopPkg.sv
design/instrReceiver.sv
design/regListScanner.sv
design/uopSequencer.sv
design/uopOutput.sv
design/uopExpander.sv
verification/uopExpanderTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= uopExpanderTb
FILELIST ?= vlog.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# Exit status comes from searching the simulator output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
